// ==== common/xbar_pkg.sv ====
/*
 * Shared definitions for the read-only AXI crossbar
 * Port counts, widths and limits, vector types for the
 * AR and R channel structs, the address rule struct and
 * the decode-error FSM states
 */
package xbar_pkg;

  // Crossbar dimensions
  localparam int NUM_SLV_PORTS = 2;
  localparam int NUM_MST_PORTS = 2;
  localparam int NUM_RULES     = 3;

  // Bus widths
  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int SLV_ID_WIDTH  = 4;
  localparam int SLV_IDX_WIDTH = $clog2(NUM_SLV_PORTS);
  // Slave port index goes on top of the ID at the master side
  localparam int MST_ID_WIDTH  = SLV_ID_WIDTH + SLV_IDX_WIDTH;
  localparam int MST_IDX_WIDTH = $clog2(NUM_MST_PORTS);
  // One extra target for the decode-error responder
  localparam int SEL_WIDTH     = $clog2(NUM_MST_PORTS + 1);

  // ID ordering
  localparam int ID_USED_BITS  = 2;
  localparam int NUM_ID_SLOTS  = 2 ** ID_USED_BITS;
  localparam int MAX_TRANS     = 4;
  localparam int CNT_WIDTH     = $clog2(MAX_TRANS + 1);

  // Response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [SLV_ID_WIDTH-1:0]  slv_id_t;
  typedef logic [MST_ID_WIDTH-1:0]  mst_id_t;
  typedef logic [7:0]               len_t;
  typedef logic [1:0]               resp_t;
  typedef logic [MST_IDX_WIDTH-1:0] mst_idx_t;
  typedef logic [SLV_IDX_WIDTH-1:0] slv_idx_t;
  typedef logic [SEL_WIDTH-1:0]     sel_t;
  typedef logic [CNT_WIDTH-1:0]     cnt_t;

  // Start is included, end is excluded
  typedef struct packed {
    mst_idx_t mst_idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ar_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_t;

  typedef enum logic {
    DECERR_IDLE,
    DECERR_BURST
  } decerr_state_t;

endpackage

// ==== demux/xbar_demux.sv ====
/*
 * AR demux of one slave port
 * Routes AR to a master link or the error link, stalls
 * reordering hazards per ID slot and merges R beats
 */
`timescale 1ns/10ps

module xbar_demux
  import xbar_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  slv_ar_t                   slv_ar_i,
  input  logic                      slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  input  sel_t                      sel_i,
  output slv_r_t                    slv_r_o,
  output logic                      slv_r_valid_o,
  input  logic                      slv_r_ready_i,
  output slv_ar_t [NUM_MST_PORTS:0] mst_ar_o,
  output logic    [NUM_MST_PORTS:0] mst_ar_valid_o,
  input  logic    [NUM_MST_PORTS:0] mst_ar_ready_i,
  input  slv_r_t  [NUM_MST_PORTS:0] mst_r_i,
  input  logic    [NUM_MST_PORTS:0] mst_r_valid_i,
  output logic    [NUM_MST_PORTS:0] mst_r_ready_o
);

  // Per ID slot in-flight count and its current target
  cnt_t [NUM_ID_SLOTS-1:0] cnt_q;
  sel_t [NUM_ID_SLOTS-1:0] sel_q;
  logic [ID_USED_BITS-1:0] ar_slot;
  logic [ID_USED_BITS-1:0] r_slot;
  logic                    stall;
  logic                    ar_fire;
  logic                    r_fire;
  logic                    r_last_fire;
  // R merge pointer and the beat picked this cycle
  sel_t                    r_rr_q;
  sel_t                    r_idx;

  assign ar_slot = slv_ar_i.id[ID_USED_BITS-1:0];

  // Another target still busy with this slot, or slot is full
  assign stall = ((cnt_q[ar_slot] != '0) && (sel_q[ar_slot] != sel_i)) ||
                 (cnt_q[ar_slot] == cnt_t'(MAX_TRANS));

  always_comb begin
    for (int j = 0; j <= NUM_MST_PORTS; j++) begin
      mst_ar_o[j]       = slv_ar_i;
      mst_ar_valid_o[j] = slv_ar_valid_i && !stall && (sel_i == sel_t'(j));
    end
  end

  assign slv_ar_ready_o = !stall && (int'(sel_i) <= NUM_MST_PORTS) && mst_ar_ready_i[sel_i];
  assign ar_fire        = slv_ar_valid_i && slv_ar_ready_o;

  // Round robin per beat, first valid at or after the pointer
  always_comb begin
    r_idx = r_rr_q;
    for (int k = NUM_MST_PORTS; k >= 0; k--) begin
      if (mst_r_valid_i[(int'(r_rr_q) + k) % (NUM_MST_PORTS + 1)]) begin
        r_idx = sel_t'((int'(r_rr_q) + k) % (NUM_MST_PORTS + 1));
      end
    end
  end

  assign slv_r_o       = mst_r_i[r_idx];
  assign slv_r_valid_o = |mst_r_valid_i;
  always_comb begin
    for (int j = 0; j <= NUM_MST_PORTS; j++) begin
      mst_r_ready_o[j] = slv_r_ready_i && (r_idx == sel_t'(j));
    end
  end

  assign r_fire      = slv_r_valid_o && slv_r_ready_i;
  assign r_last_fire = r_fire && slv_r_o.last;
  assign r_slot      = slv_r_o.id[ID_USED_BITS-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q  <= '0;
      sel_q  <= '0;
      r_rr_q <= '0;
    end else begin
      // An AR and a last beat on the same slot cancel out
      for (int s = 0; s < NUM_ID_SLOTS; s++) begin
        cnt_q[s] <= cnt_q[s] + cnt_t'(ar_fire && (int'(ar_slot) == s))
                             - cnt_t'(r_last_fire && (int'(r_slot) == s));
      end
      if (ar_fire) begin
        sel_q[ar_slot] <= sel_i;
      end
      if (r_fire) begin
        r_rr_q <= (int'(r_idx) == NUM_MST_PORTS) ? '0 : r_idx + sel_t'(1);
      end
    end
  end

  // Target select must not move under a waiting AR
  a_sel_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_ar_valid_i && !slv_ar_ready_o) |=> $stable(sel_i));

  // A last beat always belongs to a read counted on the way out
  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    r_last_fire |-> (cnt_q[r_slot] != '0));

endmodule

// ==== mux/xbar_mux.sv ====
/*
 * AR mux of one master port
 * Round-robin AR arbitration with ID prepend, and R
 * routing back by the prepended slave port index
 */
`timescale 1ns/10ps

module xbar_mux
  import xbar_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  slv_ar_t [NUM_SLV_PORTS-1:0] slv_ar_i,
  input  logic    [NUM_SLV_PORTS-1:0] slv_ar_valid_i,
  output logic    [NUM_SLV_PORTS-1:0] slv_ar_ready_o,
  output slv_r_t  [NUM_SLV_PORTS-1:0] slv_r_o,
  output logic    [NUM_SLV_PORTS-1:0] slv_r_valid_o,
  input  logic    [NUM_SLV_PORTS-1:0] slv_r_ready_i,
  output mst_ar_t                     mst_ar_o,
  output logic                        mst_ar_valid_o,
  input  logic                        mst_ar_ready_i,
  input  mst_r_t                      mst_r_i,
  input  logic                        mst_r_valid_i,
  output logic                        mst_r_ready_o
);

  slv_idx_t rr_q;
  slv_idx_t gnt_q;
  logic     lock_q;
  slv_idx_t rr_gnt;
  slv_idx_t gnt;
  slv_idx_t r_port;
  logic     ar_fire;

  // First valid port at or after the pointer
  always_comb begin
    rr_gnt = rr_q;
    for (int k = NUM_SLV_PORTS - 1; k >= 0; k--) begin
      if (slv_ar_valid_i[(int'(rr_q) + k) % NUM_SLV_PORTS]) begin
        rr_gnt = slv_idx_t'((int'(rr_q) + k) % NUM_SLV_PORTS);
      end
    end
  end

  // Keep the winner until its AR is taken
  assign gnt = lock_q ? gnt_q : rr_gnt;

  assign mst_ar_valid_o = slv_ar_valid_i[gnt];
  assign mst_ar_o.id    = {gnt, slv_ar_i[gnt].id};
  assign mst_ar_o.addr  = slv_ar_i[gnt].addr;
  assign mst_ar_o.len   = slv_ar_i[gnt].len;
  assign ar_fire        = mst_ar_valid_o && mst_ar_ready_i;

  always_comb begin
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      slv_ar_ready_o[i] = mst_ar_ready_i && (gnt == slv_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q   <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= mst_ar_valid_o && !mst_ar_ready_i;
      gnt_q  <= gnt;
      if (ar_fire) begin
        rr_q <= slv_idx_t'((int'(gnt) + 1) % NUM_SLV_PORTS);
      end
    end
  end

  // Top ID bits name the slave port the beat returns to
  assign r_port = mst_r_i.id[MST_ID_WIDTH-1 -: SLV_IDX_WIDTH];

  always_comb begin
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      slv_r_o[i].id    = mst_r_i.id[SLV_ID_WIDTH-1:0];
      slv_r_o[i].data  = mst_r_i.data;
      slv_r_o[i].resp  = mst_r_i.resp;
      slv_r_o[i].last  = mst_r_i.last;
      slv_r_valid_o[i] = mst_r_valid_i && (r_port == slv_idx_t'(i));
    end
  end

  assign mst_r_ready_o = slv_r_ready_i[r_port];

  // Granted AR and its extended ID hold while the master port stalls
  a_ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=> (mst_ar_valid_o && $stable(mst_ar_o)));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the run by its log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_xbar -f verilog.f \
  -o sim_xbar && ./obj_dir/sim_xbar > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/xbar_addr_decode.sv ====
/*
 * Address decoder of one slave port
 * Maps a read address onto a master port, the default
 * port or the decode-error target
 */
`timescale 1ns/10ps

module xbar_addr_decode
  import xbar_pkg::*;
(
  input  addr_t                  addr_i,
  input  rule_t [NUM_RULES-1:0]  addr_map_i,
  input  logic                   en_default_i,
  input  mst_idx_t               default_port_i,
  output sel_t                   sel_o
);

  logic match;

  always_comb begin
    match = 1'b0;
    // No hit means decode error unless the default port takes it
    sel_o = sel_t'(NUM_MST_PORTS);
    // Later rules overwrite earlier ones, so the highest index wins
    for (int r = 0; r < NUM_RULES; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        match = 1'b1;
        sel_o = sel_t'(addr_map_i[r].mst_idx);
      end
    end
    // Fall back to the per-port default master
    if (!match && en_default_i) begin
      sel_o = sel_t'(default_port_i);
    end
  end

endmodule

// ==== src/xbar_decerr.sv ====
/*
 * Decode-error read responder
 * Takes one AR at a time and answers with len+1
 * zero-data DECERR beats
 */
`timescale 1ns/10ps

module xbar_decerr
  import xbar_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  slv_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output slv_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  decerr_state_t state_q;
  slv_id_t       id_q;
  len_t          len_q;
  // Beats already sent of the current burst
  len_t          beat_q;

  assign ar_ready_o = (state_q == DECERR_IDLE);
  assign r_valid_o  = (state_q == DECERR_BURST);

  assign r_o.id   = id_q;
  assign r_o.data = '0;
  assign r_o.resp = RESP_DECERR;
  assign r_o.last = (beat_q == len_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= DECERR_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        DECERR_IDLE: begin
          if (ar_valid_i) begin
            state_q <= DECERR_BURST;
            beat_q  <= '0;
          end
        end
        DECERR_BURST: begin
          if (r_ready_i) begin
            if (r_o.last) begin
              state_q <= DECERR_IDLE;
            end else begin
              beat_q <= beat_q + len_t'(1);
            end
          end
        end
        default: state_q <= DECERR_IDLE;
      endcase
    end
  end

  // ID and length of the accepted request
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q  <= ar_i.id;
      len_q <= ar_i.len;
    end
  end

  // Beat count stays within the latched burst length
  a_beat_in_burst: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == DECERR_BURST) |-> (beat_q <= len_q));

endmodule

// ==== src/xbar_top.sv ====
/*
 * Read-only AXI crossbar top level
 * Decoders, demuxes and error responders per slave port,
 * muxes per master port and the crosspoint links
 */
`timescale 1ns/10ps

module xbar_top
  import xbar_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  slv_ar_t  [NUM_SLV_PORTS-1:0] slv_ar_i,
  input  logic     [NUM_SLV_PORTS-1:0] slv_ar_valid_i,
  output logic     [NUM_SLV_PORTS-1:0] slv_ar_ready_o,
  output slv_r_t   [NUM_SLV_PORTS-1:0] slv_r_o,
  output logic     [NUM_SLV_PORTS-1:0] slv_r_valid_o,
  input  logic     [NUM_SLV_PORTS-1:0] slv_r_ready_i,
  output mst_ar_t  [NUM_MST_PORTS-1:0] mst_ar_o,
  output logic     [NUM_MST_PORTS-1:0] mst_ar_valid_o,
  input  logic     [NUM_MST_PORTS-1:0] mst_ar_ready_i,
  input  mst_r_t   [NUM_MST_PORTS-1:0] mst_r_i,
  input  logic     [NUM_MST_PORTS-1:0] mst_r_valid_i,
  output logic     [NUM_MST_PORTS-1:0] mst_r_ready_o,
  input  rule_t    [NUM_RULES-1:0]     addr_map_i,
  input  logic     [NUM_SLV_PORTS-1:0] en_default_i,
  input  mst_idx_t [NUM_SLV_PORTS-1:0] default_port_i
);

  sel_t [NUM_SLV_PORTS-1:0] ar_sel;

  // Demux side links, last index is the error target
  slv_ar_t [NUM_SLV_PORTS-1:0][NUM_MST_PORTS:0] dmx_ar;
  logic    [NUM_SLV_PORTS-1:0][NUM_MST_PORTS:0] dmx_ar_valid, dmx_ar_ready;
  slv_r_t  [NUM_SLV_PORTS-1:0][NUM_MST_PORTS:0] dmx_r;
  logic    [NUM_SLV_PORTS-1:0][NUM_MST_PORTS:0] dmx_r_valid, dmx_r_ready;

  // Mux side links, indexed master port first
  slv_ar_t [NUM_MST_PORTS-1:0][NUM_SLV_PORTS-1:0] mux_ar;
  logic    [NUM_MST_PORTS-1:0][NUM_SLV_PORTS-1:0] mux_ar_valid, mux_ar_ready;
  slv_r_t  [NUM_MST_PORTS-1:0][NUM_SLV_PORTS-1:0] mux_r;
  logic    [NUM_MST_PORTS-1:0][NUM_SLV_PORTS-1:0] mux_r_valid, mux_r_ready;

  for (genvar i = 0; i < NUM_SLV_PORTS; i++) begin : g_slv
    xbar_addr_decode i_decode (
      .addr_i         ( slv_ar_i[i].addr  ),
      .addr_map_i     ( addr_map_i        ),
      .en_default_i   ( en_default_i[i]   ),
      .default_port_i ( default_port_i[i] ),
      .sel_o          ( ar_sel[i]         )
    );

    xbar_demux i_demux (
      .clk_i          ( clk_i             ),
      .reset_i        ( reset_i           ),
      .slv_ar_i       ( slv_ar_i[i]       ),
      .slv_ar_valid_i ( slv_ar_valid_i[i] ),
      .slv_ar_ready_o ( slv_ar_ready_o[i] ),
      .sel_i          ( ar_sel[i]         ),
      .slv_r_o        ( slv_r_o[i]        ),
      .slv_r_valid_o  ( slv_r_valid_o[i]  ),
      .slv_r_ready_i  ( slv_r_ready_i[i]  ),
      .mst_ar_o       ( dmx_ar[i]         ),
      .mst_ar_valid_o ( dmx_ar_valid[i]   ),
      .mst_ar_ready_i ( dmx_ar_ready[i]   ),
      .mst_r_i        ( dmx_r[i]          ),
      .mst_r_valid_i  ( dmx_r_valid[i]    ),
      .mst_r_ready_o  ( dmx_r_ready[i]    )
    );

    // Unmapped reads end here
    xbar_decerr i_decerr (
      .clk_i      ( clk_i                           ),
      .reset_i    ( reset_i                         ),
      .ar_i       ( dmx_ar[i][NUM_MST_PORTS]        ),
      .ar_valid_i ( dmx_ar_valid[i][NUM_MST_PORTS]  ),
      .ar_ready_o ( dmx_ar_ready[i][NUM_MST_PORTS]  ),
      .r_o        ( dmx_r[i][NUM_MST_PORTS]         ),
      .r_valid_o  ( dmx_r_valid[i][NUM_MST_PORTS]   ),
      .r_ready_i  ( dmx_r_ready[i][NUM_MST_PORTS]   )
    );

    // Crosspoint transpose
    for (genvar j = 0; j < NUM_MST_PORTS; j++) begin : g_xp
      assign mux_ar[j][i]       = dmx_ar[i][j];
      assign mux_ar_valid[j][i] = dmx_ar_valid[i][j];
      assign dmx_ar_ready[i][j] = mux_ar_ready[j][i];
      assign dmx_r[i][j]        = mux_r[j][i];
      assign dmx_r_valid[i][j]  = mux_r_valid[j][i];
      assign mux_r_ready[j][i]  = dmx_r_ready[i][j];
    end
  end

  for (genvar j = 0; j < NUM_MST_PORTS; j++) begin : g_mst
    xbar_mux i_mux (
      .clk_i          ( clk_i             ),
      .reset_i        ( reset_i           ),
      .slv_ar_i       ( mux_ar[j]         ),
      .slv_ar_valid_i ( mux_ar_valid[j]   ),
      .slv_ar_ready_o ( mux_ar_ready[j]   ),
      .slv_r_o        ( mux_r[j]          ),
      .slv_r_valid_o  ( mux_r_valid[j]    ),
      .slv_r_ready_i  ( mux_r_ready[j]    ),
      .mst_ar_o       ( mst_ar_o[j]       ),
      .mst_ar_valid_o ( mst_ar_valid_o[j] ),
      .mst_ar_ready_i ( mst_ar_ready_i[j] ),
      .mst_r_i        ( mst_r_i[j]        ),
      .mst_r_valid_i  ( mst_r_valid_i[j]  ),
      .mst_r_ready_o  ( mst_r_ready_o[j]  )
    );
  end

endmodule

// ==== tb/tb_xbar.sv ====
/*
 * Testbench of the read-only AXI crossbar
 * Clock, reset, DUT with one memory model per master port,
 * check task and directed tests for routing, bursts, decode
 * error, default port, arbitration and ID ordering
 */
`timescale 1ns/10ps

module tb_xbar
  import xbar_pkg::*;
();

  localparam int CLK_HALF     = 2;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 5;
  // Cycles any single wait may take
  localparam int WAIT_LIMIT   = 200;

  logic                         clk;
  logic                         reset;
  slv_ar_t  [NUM_SLV_PORTS-1:0] slv_ar;
  logic     [NUM_SLV_PORTS-1:0] slv_ar_valid;
  logic     [NUM_SLV_PORTS-1:0] slv_ar_ready;
  slv_r_t   [NUM_SLV_PORTS-1:0] slv_r;
  logic     [NUM_SLV_PORTS-1:0] slv_r_valid;
  logic     [NUM_SLV_PORTS-1:0] slv_r_ready;
  mst_ar_t  [NUM_MST_PORTS-1:0] mst_ar;
  logic     [NUM_MST_PORTS-1:0] mst_ar_valid;
  logic     [NUM_MST_PORTS-1:0] mst_ar_ready;
  mst_r_t   [NUM_MST_PORTS-1:0] mst_r;
  logic     [NUM_MST_PORTS-1:0] mst_r_valid;
  logic     [NUM_MST_PORTS-1:0] mst_r_ready;
  rule_t    [NUM_RULES-1:0]     addr_map;
  logic     [NUM_SLV_PORTS-1:0] en_default;
  mst_idx_t [NUM_SLV_PORTS-1:0] default_port;

  xbar_top i_xbar_top (
    .clk_i          ( clk          ),
    .reset_i        ( reset        ),
    .slv_ar_i       ( slv_ar       ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_r_o        ( slv_r        ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .mst_ar_o       ( mst_ar       ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_r_i        ( mst_r        ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_o  ( mst_r_ready  ),
    .addr_map_i     ( addr_map     ),
    .en_default_i   ( en_default   ),
    .default_port_i ( default_port )
  );

  // Port 0 is the slow memory
  for (genvar j = 0; j < NUM_MST_PORTS; j++) begin : g_slave
    xbar_tb_slave #(
      .PORT_IDX ( j                ),
      .LATENCY  ( (j == 0) ? 10 : 1 )
    ) i_slave (
      .clk_i      ( clk             ),
      .reset_i    ( reset           ),
      .ar_i       ( mst_ar[j]       ),
      .ar_valid_i ( mst_ar_valid[j] ),
      .ar_ready_o ( mst_ar_ready[j] ),
      .r_o        ( mst_r[j]        ),
      .r_valid_o  ( mst_r_valid[j]  ),
      .r_ready_i  ( mst_r_ready[j]  )
    );
  end

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_equal(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    stop_run();
  endtask

  // Memory data with the master port plus one in the top nibble
  function automatic data_t expected_data(input addr_t addr, input int beat, input int port);
    data_t d;
    d = addr + data_t'(4 * beat);
    d[31:28] = 4'(port + 1);
    return d;
  endfunction

  task automatic set_rule(input int idx, input int port, input addr_t start_addr,
                          input addr_t end_addr);
    addr_map[idx].mst_idx    = mst_idx_t'(port);
    addr_map[idx].start_addr = start_addr;
    addr_map[idx].end_addr   = end_addr;
  endtask

  // Called just after an edge, returns just after the AR transfer
  task automatic send_ar(input int p, input slv_id_t id, input addr_t addr, input len_t len);
    int waited;
    waited = 0;
    slv_ar[p].id    = id;
    slv_ar[p].addr  = addr;
    slv_ar[p].len   = len;
    slv_ar_valid[p] = 1'b1;
    @(posedge clk);
    while (!slv_ar_ready[p]) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout($sformatf("AR ready on slave port %0d", p));
      end else begin
        @(posedge clk);
      end
    end
    #DRIVE_DELAY;
    slv_ar_valid[p] = 1'b0;
  endtask

  // Collects len+1 beats on one slave port and checks each
  task automatic receive_burst(input int p, input slv_id_t id, input addr_t addr,
                               input len_t len, input int port, input logic decerr);
    int     waited;
    slv_r_t beat;
    for (int b = 0; b <= int'(len); b++) begin
      waited = 0;
      @(posedge clk);
      while (!(slv_r_valid[p] && slv_r_ready[p])) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          report_timeout($sformatf("R beat %0d on slave port %0d", b, p));
        end else begin
          @(posedge clk);
        end
      end
      beat = slv_r[p];
      check_equal("R id", 64'(beat.id), 64'(id));
      check_equal("R data", 64'(beat.data), decerr ? 64'(0) : 64'(expected_data(addr, b, port)));
      check_equal("R resp", 64'(beat.resp), decerr ? 64'(RESP_DECERR) : 64'(RESP_OKAY));
      check_equal("R last", 64'(beat.last), 64'(b == int'(len)));
    end
  endtask

  task automatic read_check(input int p, input slv_id_t id, input addr_t addr, input len_t len,
                            input int port, input logic decerr);
    fork
      send_ar(p, id, addr, len);
      receive_burst(p, id, addr, len, port, decerr);
    join
    #DRIVE_DELAY;
  endtask

  // One read into each rule from each slave port
  task automatic routing_test();
    for (int p = 0; p < NUM_SLV_PORTS; p++) begin
      read_check(p, slv_id_t'(p + 1), 32'h0000_1000, 8'd0, 0, 1'b0);
      read_check(p, slv_id_t'(p + 4), 32'h1000_2000, 8'd0, 1, 1'b0);
      read_check(p, slv_id_t'(p + 8), 32'h1800_0100, 8'd0, 0, 1'b0);
    end
  endtask

  task automatic burst_test();
    read_check(0, 4'h6, 32'h1000_0040, 8'd3, 1, 1'b0);
    read_check(1, 4'h2, 32'h0000_0200, 8'd3, 0, 1'b0);
  endtask

  task automatic decode_error_test();
    en_default = '0;
    read_check(0, 4'h3, 32'h3000_0000, 8'd2, 0, 1'b1);
    read_check(1, 4'hc, 32'h3000_0000, 8'd0, 0, 1'b1);
  endtask

  task automatic default_port_test();
    en_default[0]   = 1'b1;
    default_port[0] = mst_idx_t'(1);
    read_check(0, 4'h4, 32'h3000_0000, 8'd1, 1, 1'b0);
    en_default[0]   = 1'b0;
    default_port[0] = '0;
  endtask

  // Both slave ports hit master port 1 in the same cycle
  task automatic arbitration_test();
    fork
      read_check(0, 4'h5, 32'h1000_1000, 8'd1, 1, 1'b0);
      read_check(1, 4'h9, 32'h1000_2000, 8'd1, 1, 1'b0);
    join
  endtask

  // Beats of one ID stay in order across the slow and the fast port
  task automatic id_ordering_test();
    fork
      begin
        send_ar(0, 4'h1, 32'h0000_0400, 8'd1);
        send_ar(0, 4'h1, 32'h1000_0400, 8'd1);
      end
      begin
        receive_burst(0, 4'h1, 32'h0000_0400, 8'd1, 0, 1'b0);
        receive_burst(0, 4'h1, 32'h1000_0400, 8'd1, 1, 1'b0);
      end
    join
    #DRIVE_DELAY;
  endtask

  initial begin
    reset        = 1'b1;
    slv_ar       = '0;
    slv_ar_valid = '0;
    slv_r_ready  = '0;
    en_default   = '0;
    default_port = '0;
    addr_map     = '0;
    set_rule(0, 0, 32'h0000_0000, 32'h1000_0000);
    set_rule(1, 1, 32'h1000_0000, 32'h2000_0000);
    // Overlaps rule 1 and wins by its higher index
    set_rule(2, 0, 32'h1800_0000, 32'h1900_0000);
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset       = 1'b0;
    slv_r_ready = '1;
    routing_test();
    burst_test();
    decode_error_test();
    default_port_test();
    arbitration_test();
    id_ordering_test();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== tb/xbar_tb_slave.sv ====
/*
 * Behavioral memory model behind one master port
 * Takes one AR at a time, waits a fixed latency and returns
 * len+1 beats tagged with the port index
 */
`timescale 1ns/10ps

module xbar_tb_slave
  import xbar_pkg::*;
#(
  parameter int PORT_IDX = 0,
  parameter int LATENCY  = 1
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  mst_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output mst_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  // Model state starts defined so the DUT never sees X
  logic    busy_q  = 1'b0;
  int      delay_q = 0;
  mst_id_t id_q    = '0;
  addr_t   addr_q  = '0;
  len_t    len_q   = '0;
  len_t    beat_q  = '0;

  // Address plus four per beat, top nibble carries the port tag
  function automatic data_t beat_data(input addr_t addr, input len_t beat);
    data_t d;
    d = addr + data_t'(4 * int'(beat));
    d[31:28] = 4'(PORT_IDX + 1);
    return d;
  endfunction

  assign ar_ready_o = !busy_q;
  assign r_valid_o  = busy_q && (delay_q == 0);
  assign r_o.id     = id_q;
  assign r_o.data   = beat_data(addr_q, beat_q);
  assign r_o.resp   = RESP_OKAY;
  assign r_o.last   = (beat_q == len_q);

  always @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      delay_q <= 0;
      beat_q  <= '0;
    end else if (!busy_q) begin
      // Latch the request and start the latency count
      if (ar_valid_i) begin
        busy_q  <= 1'b1;
        id_q    <= ar_i.id;
        addr_q  <= ar_i.addr;
        len_q   <= ar_i.len;
        beat_q  <= '0;
        delay_q <= LATENCY - 1;
      end
    end else if (delay_q != 0) begin
      delay_q <= delay_q - 1;
    end else if (r_ready_i) begin
      if (beat_q == len_q) begin
        busy_q <= 1'b0;
      end else begin
        beat_q <= beat_q + len_t'(1);
      end
    end
  end

endmodule

// ==== verilog.f ====
common/xbar_pkg.sv
src/xbar_addr_decode.sv
demux/xbar_demux.sv
src/xbar_decerr.sv
mux/xbar_mux.sv
src/xbar_top.sv
tb/xbar_tb_slave.sv
tb/tb_xbar.sv
